// File: Makefile
VERILATOR ?= verilator
TOP       ?= cnn_ctrl_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/apb_ctrl_regs.sv
module apb_ctrl_regs #(
    parameter int RESULT_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_psel,
    input  logic                     i_penable,
    input  logic                     i_pwrite,
    input  cnn_regs_pkg::apb_addr_t  i_paddr,
    input  cnn_regs_pkg::apb_data_t  i_pwdata,
    output cnn_regs_pkg::apb_data_t  o_prdata,
    input  logic                     i_fifo_full,
    input  logic                     i_result_we,
    input  cnn_cmd_pkg::cmd_count_t  i_result_idx,
    input  cnn_cmd_pkg::result_t     i_result_elems,
    input  cnn_cmd_pkg::result_t     i_result_macs,
    input  logic [2:0]               i_state,
    input  cnn_cmd_pkg::cmd_count_t  i_done_count,
    input  logic                     i_irq,
    output logic                     o_push,
    output cnn_cmd_pkg::cmd_word_t   o_push_data,
    output logic                     o_op_en,
    output logic                     o_restart,
    output cnn_cmd_pkg::cmd_count_t  o_cmd_count
);
    import cnn_cmd_pkg::*;
    import cnn_regs_pkg::*;

    localparam int        IDX_W      = $clog2(RESULT_DEPTH);
    localparam apb_addr_t RESULT_END = apb_addr_t'(RESULT_BASE + 8 * RESULT_DEPTH);

    result_t    elems_mem [RESULT_DEPTH];
    result_t    macs_mem  [RESULT_DEPTH];
    logic       wr_en;
    logic       overflow;
    logic       res_hit;
    apb_addr_t  res_off;
    logic [IDX_W-1:0] res_slot;

    // Writes land at the end of the access phase
    assign wr_en       = i_psel && i_penable && i_pwrite;
    assign o_push      = wr_en && (i_paddr == REG_CMD_DATA);
    assign o_push_data = i_pwdata;

    // Result window holds an element and a MAC word per slot
    assign res_hit  = (i_paddr >= RESULT_BASE) && (i_paddr < RESULT_END);
    assign res_off  = i_paddr - RESULT_BASE;
    assign res_slot = res_off[3 +: IDX_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_op_en     <= 1'b0;
            o_restart   <= 1'b0;
            o_cmd_count <= '0;
            overflow    <= 1'b0;
        end else begin
            // Restart lasts one cycle
            o_restart <= wr_en && (i_paddr == REG_CTRL) && i_pwdata[CTRL_RESTART_BIT];
            if (wr_en && (i_paddr == REG_CTRL)) begin
                o_op_en <= i_pwdata[CTRL_OP_EN_BIT];
            end
            if (wr_en && (i_paddr == REG_CMD_COUNT)) begin
                o_cmd_count <= cmd_count_t'(i_pwdata);
            end
            // Sticky until reset
            if (o_push && i_fifo_full) begin
                overflow <= 1'b1;
            end
        end
    end

    // Index wraps modulo the memory depth
    always_ff @(posedge clk) begin
        if (i_result_we) begin
            elems_mem[i_result_idx[IDX_W-1:0]] <= i_result_elems;
            macs_mem[i_result_idx[IDX_W-1:0]]  <= i_result_macs;
        end
    end

    // Read mux, zero for unmapped and write-only addresses
    always_comb begin
        o_prdata = '0;
        if (i_psel && !i_pwrite) begin
            if (res_hit) begin
                o_prdata = res_off[2] ? macs_mem[res_slot] : elems_mem[res_slot];
            end else begin
                case (i_paddr)
                    REG_CTRL: o_prdata[CTRL_OP_EN_BIT] = o_op_en;
                    REG_CMD_COUNT: o_prdata[$bits(cmd_count_t)-1:0] = o_cmd_count;
                    REG_STATUS: begin
                        o_prdata[STAT_STATE_LSB +: 3] = i_state;
                        o_prdata[STAT_IRQ_BIT]        = i_irq;
                        o_prdata[STAT_OVF_BIT]        = overflow;
                        o_prdata[STAT_DONE_LSB +: $bits(cmd_count_t)] = i_done_count;
                    end
                    default: o_prdata = '0;
                endcase
            end
        end
    end

endmodule

// File: rtl/cmd_fifo.sv
module cmd_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_push,
    input  cnn_cmd_pkg::cmd_word_t i_push_data,
    input  logic                   i_pop,
    output logic                   o_valid,
    output cnn_cmd_pkg::cmd_word_t o_head,
    output logic                   o_full
);
    import cnn_cmd_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cmd_word_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Head word falls through whenever data is present
    assign o_valid = (count != '0);
    assign o_full  = (count == CNT_W'(FIFO_DEPTH));
    assign o_head  = mem[rd_ptr];

    // Full pushes are dropped, empty pops ignored
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && o_valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the depth, which need not be a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Sequencer only pops words that are present
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) i_pop |-> o_valid)
        else $error("cmd_fifo pop while empty");

endmodule

// File: rtl/cmd_sequencer.sv
module cmd_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_op_en,
    input  logic                    i_restart,
    input  cnn_cmd_pkg::cmd_count_t i_cmd_count,
    input  logic                    i_fifo_valid,
    input  cnn_cmd_pkg::cmd_word_t  i_fifo_head,
    input  logic                    i_engine_ready,
    output logic                    o_fifo_pop,
    output logic                    o_engine_valid,
    output cnn_cmd_pkg::op_type_e   o_op_type,
    output cnn_cmd_pkg::stride_t    o_stride,
    output cnn_cmd_pkg::kernel_t    o_kernel,
    output cnn_cmd_pkg::side_t      o_i_side,
    output cnn_cmd_pkg::side_t      o_o_side,
    output cnn_cmd_pkg::channel_t   o_i_channel,
    output cnn_cmd_pkg::channel_t   o_o_channel,
    output cnn_cmd_pkg::ksize_t     o_kernel_size,
    output cnn_cmd_pkg::stride2_t   o_stride2,
    output logic                    o_result_we,
    output cnn_cmd_pkg::cmd_count_t o_done_count,
    output logic [2:0]              o_state,
    output logic                    o_irq
);
    import cnn_cmd_pkg::*;

    typedef enum logic [2:0] {
        IDLE      = 3'b000,
        CMD_GET   = 3'b001,
        CMD_ISSUE = 3'b010,
        OP_RUN    = 3'b011,
        FINISH    = 3'b100
    } state_e;

    state_e     state;
    state_e     next_state;
    logic [1:0] word_cnt;
    logic       last_word;
    logic       run_done;

    // Pop as soon as a word is waiting in the collect state
    assign o_fifo_pop  = (state == CMD_GET) && i_fifo_valid;
    assign last_word   = (word_cnt == 2'(CMD_WORDS - 1));
    // Result is stored in the cycle the engine reports completion
    assign o_result_we = (state == OP_RUN) && i_engine_ready;
    // Current command is the last one of the run
    assign run_done    = (cmd_count_t'(o_done_count + 1'b1) == i_cmd_count);
    assign o_state     = state;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // An empty run goes straight to finish
                if (i_op_en) begin
                    next_state = (i_cmd_count == '0) ? FINISH : CMD_GET;
                end
            end
            CMD_GET: begin
                if (o_fifo_pop && last_word) begin
                    next_state = CMD_ISSUE;
                end
            end
            CMD_ISSUE: begin
                next_state = OP_RUN;
            end
            OP_RUN: begin
                if (i_engine_ready) begin
                    next_state = run_done ? FINISH : CMD_GET;
                end
            end
            FINISH: begin
                if (i_restart) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= IDLE;
            word_cnt       <= '0;
            o_engine_valid <= 1'b0;
            o_done_count   <= '0;
            o_irq          <= 1'b0;
        end else begin
            state <= next_state;
            // Word counter steps per popped word
            if (o_fifo_pop) begin
                word_cnt <= last_word ? 2'd0 : word_cnt + 1'b1;
            end
            // Valid rises on issue and falls after the ready pulse
            if (state == CMD_ISSUE) begin
                o_engine_valid <= 1'b1;
            end else if (o_result_we) begin
                o_engine_valid <= 1'b0;
            end
            if (o_result_we) begin
                o_done_count <= o_done_count + 1'b1;
            end
            // irq holds in finish until restart
            if (state == FINISH) begin
                o_irq <= !i_restart;
                if (i_restart) begin
                    o_done_count <= '0;
                end
            end
        end
    end

    // Unpack command words into layer fields
    always_ff @(posedge clk) begin
        if (o_fifo_pop) begin
            case (word_cnt)
                2'd0: begin
                    o_op_type <= op_type_e'(i_fifo_head[W0_OP_LSB +: $bits(op_type_e)]);
                    o_stride  <= i_fifo_head[W0_STRIDE_LSB +: $bits(stride_t)];
                    o_kernel  <= i_fifo_head[W0_KERNEL_LSB +: $bits(kernel_t)];
                    o_i_side  <= i_fifo_head[W0_I_SIDE_LSB +: $bits(side_t)];
                    o_o_side  <= i_fifo_head[W0_O_SIDE_LSB +: $bits(side_t)];
                end
                2'd1: begin
                    o_i_channel <= i_fifo_head[W1_I_CHAN_LSB +: $bits(channel_t)];
                    o_o_channel <= i_fifo_head[W1_O_CHAN_LSB +: $bits(channel_t)];
                end
                default: begin
                    o_kernel_size <= i_fifo_head[W2_KSIZE_LSB +: $bits(ksize_t)];
                    o_stride2     <= i_fifo_head[W2_STRIDE2_LSB +: $bits(stride2_t)];
                end
            endcase
        end
    end

    // Engine completion is a single-cycle pulse
    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        i_engine_ready |=> !i_engine_ready)
        else $error("engine_ready held longer than one cycle");

endmodule

// File: rtl/cnn_cmd_pkg.sv
package cnn_cmd_pkg;

    // One word as pushed through the command FIFO
    typedef logic [31:0] cmd_word_t;

    // Layer operation codes
    typedef enum logic [2:0] {
        OP_IDLE      = 3'b000,
        OP_CONV_RELU = 3'b001,
        OP_MAX_POOL  = 3'b100,
        OP_AVG_POOL  = 3'b101
    } op_type_e;

    // Layer field types
    typedef logic [3:0]  stride_t;
    typedef logic [7:0]  kernel_t;
    typedef logic [7:0]  side_t;
    typedef logic [15:0] channel_t;
    typedef logic [7:0]  ksize_t;
    typedef logic [15:0] stride2_t;

    // Command counter and result figure
    typedef logic [6:0]  cmd_count_t;
    typedef logic [31:0] result_t;

    // Words per command
    localparam int CMD_WORDS = 3;

    // Word 0 field positions
    localparam int W0_OP_LSB      = 0;
    localparam int W0_STRIDE_LSB  = 4;
    localparam int W0_KERNEL_LSB  = 8;
    localparam int W0_I_SIDE_LSB  = 16;
    localparam int W0_O_SIDE_LSB  = 24;
    // Word 1 field positions
    localparam int W1_I_CHAN_LSB  = 0;
    localparam int W1_O_CHAN_LSB  = 16;
    // Word 2 field positions
    localparam int W2_KSIZE_LSB   = 8;
    localparam int W2_STRIDE2_LSB = 16;

endpackage

// File: rtl/cnn_ctrl_top.sv
module cnn_ctrl_top #(
    parameter int FIFO_DEPTH   = 16,
    parameter int RESULT_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  cnn_regs_pkg::apb_addr_t i_paddr,
    input  cnn_regs_pkg::apb_data_t i_pwdata,
    output cnn_regs_pkg::apb_data_t o_prdata,
    output logic                    o_irq
);
    import cnn_cmd_pkg::*;

    // FIFO push and pop path
    logic       push;
    cmd_word_t  push_data;
    logic       fifo_valid;
    cmd_word_t  fifo_head;
    logic       fifo_full;
    logic       fifo_pop;
    // Run control
    logic       op_en;
    logic       restart;
    cmd_count_t cmd_count;
    cmd_count_t done_count;
    logic [2:0] state;
    // Engine handshake and layer fields
    logic       engine_valid;
    logic       engine_ready;
    op_type_e   op_type;
    kernel_t    kernel;
    side_t      o_side;
    channel_t   i_channel;
    channel_t   o_channel;
    // Result write
    logic       result_we;
    result_t    result_elems;
    result_t    result_macs;

    apb_ctrl_regs #(.RESULT_DEPTH(RESULT_DEPTH)) apb_ctrl_regs_i (
        .clk, .rst, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata, .o_prdata,
        .i_fifo_full(fifo_full), .i_result_we(result_we), .i_result_idx(done_count),
        .i_result_elems(result_elems), .i_result_macs(result_macs), .i_state(state),
        .i_done_count(done_count), .i_irq(o_irq), .o_push(push), .o_push_data(push_data),
        .o_op_en(op_en), .o_restart(restart), .o_cmd_count(cmd_count)
    );

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo_i (
        .clk, .rst, .i_push(push), .i_push_data(push_data), .i_pop(fifo_pop),
        .o_valid(fifo_valid), .o_head(fifo_head), .o_full(fifo_full)
    );

    // Stride, input side, kernel size and stride2 stay inside the sequencer
    cmd_sequencer cmd_sequencer_i (
        .clk, .rst, .i_op_en(op_en), .i_restart(restart), .i_cmd_count(cmd_count),
        .i_fifo_valid(fifo_valid), .i_fifo_head(fifo_head), .i_engine_ready(engine_ready),
        .o_fifo_pop(fifo_pop), .o_engine_valid(engine_valid), .o_op_type(op_type),
        .o_stride(), .o_kernel(kernel), .o_i_side(), .o_o_side(o_side),
        .o_i_channel(i_channel), .o_o_channel(o_channel), .o_kernel_size(), .o_stride2(),
        .o_result_we(result_we), .o_done_count(done_count), .o_state(state), .o_irq(o_irq)
    );

    layer_engine layer_engine_i (
        .clk, .rst, .i_engine_valid(engine_valid), .i_op_type(op_type), .i_kernel(kernel),
        .i_o_side(o_side), .i_i_channel(i_channel), .i_o_channel(o_channel),
        .o_engine_ready(engine_ready), .o_result_elems(result_elems),
        .o_result_macs(result_macs)
    );

endmodule

// File: rtl/cnn_regs_pkg.sv
package cnn_regs_pkg;

    // APB bus widths
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Register map
    localparam apb_addr_t REG_CTRL      = 12'h000;
    localparam apb_addr_t REG_CMD_COUNT = 12'h004;
    localparam apb_addr_t REG_CMD_DATA  = 12'h008;
    localparam apb_addr_t REG_STATUS    = 12'h00C;
    localparam apb_addr_t RESULT_BASE   = 12'h100;

    // CTRL bits
    localparam int CTRL_OP_EN_BIT   = 0;
    localparam int CTRL_RESTART_BIT = 1;

    // STATUS fields
    localparam int STAT_STATE_LSB = 0;
    localparam int STAT_IRQ_BIT   = 4;
    localparam int STAT_OVF_BIT   = 5;
    localparam int STAT_DONE_LSB  = 8;

endpackage

// File: rtl/layer_engine.sv
module layer_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_engine_valid,
    input  cnn_cmd_pkg::op_type_e i_op_type,
    input  cnn_cmd_pkg::kernel_t  i_kernel,
    input  cnn_cmd_pkg::side_t    i_o_side,
    input  cnn_cmd_pkg::channel_t i_i_channel,
    input  cnn_cmd_pkg::channel_t i_o_channel,
    output logic                  o_engine_ready,
    output cnn_cmd_pkg::result_t  o_result_elems,
    output cnn_cmd_pkg::result_t  o_result_macs
);
    import cnn_cmd_pkg::*;

    logic                         busy;
    logic                         start;
    logic [$bits(side_t):0]       row_cnt;
    logic [2*$bits(side_t)-1:0]   area;
    logic [2*$bits(kernel_t)-1:0] kk;
    result_t                      per_elem;
    logic                         op_known;

    assign start    = !busy && i_engine_valid;
    assign op_known = (i_op_type == OP_CONV_RELU) || (i_op_type == OP_MAX_POOL) ||
                      (i_op_type == OP_AVG_POOL);
    // One cycle per output row plus two cycles of setup
    assign o_engine_ready = busy && (row_cnt == ({1'b0, i_o_side} + 1'b1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            row_cnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            row_cnt <= '0;
        end else if (o_engine_ready) begin
            busy <= 1'b0;
        end else if (busy) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // Products are staged over the first rows
    always_ff @(posedge clk) begin
        if (start) begin
            area          <= i_o_side * i_o_side;
            kk            <= i_kernel * i_kernel;
            o_result_macs <= '0;
        end else if (busy && (row_cnt == '0)) begin
            // Unknown codes give zero elements and so zero MACs
            o_result_elems <= op_known ? area * result_t'(i_o_channel) : '0;
            // Convolution sums over input channels, pooling does not
            per_elem <= (i_op_type == OP_CONV_RELU) ?
                        result_t'(kk) * result_t'(i_i_channel) : result_t'(kk);
        end else if (busy && (row_cnt == 1)) begin
            o_result_macs <= o_result_elems * per_elem;
        end
    end

    // Completion only answers a pending request
    a_ready_in_req: assert property (@(posedge clk) disable iff (rst)
        o_engine_ready |-> i_engine_valid)
        else $error("engine_ready without engine_valid");

endmodule

// File: verif/cnn_ctrl_checker.sv
module cnn_ctrl_checker #(
    parameter int FIFO_DEPTH   = 16,
    parameter int RESULT_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  cnn_regs_pkg::apb_addr_t i_paddr,
    input  cnn_regs_pkg::apb_data_t i_pwdata,
    input  cnn_regs_pkg::apb_data_t i_prdata,
    input  logic                    i_irq,
    output int                      o_errors,
    output int                      o_result_checks
);
    import cnn_cmd_pkg::*;
    import cnn_regs_pkg::*;

    // Every command word the FIFO accepted, in push order
    cmd_word_t words [$];
    // Commands consumed by finished runs
    int   run_base    = 0;
    int   last_done   = 0;
    int   cmd_count   = 0;
    logic ovf_exp     = 1'b0;
    logic idle_exp    = 1'b1;
    logic run_started = 1'b0;
    logic irq_q       = 1'b0;

    initial begin
        o_errors        = 0;
        o_result_checks = 0;
    end

    // Reference figures {macs, elems} for one command
    function automatic logic [63:0] layer_figures(cmd_word_t w0, cmd_word_t w1);
        result_t side;
        result_t k;
        result_t ich;
        result_t och;
        result_t elems;
        result_t macs;
        side  = result_t'(w0[31:24]);
        k     = result_t'(w0[15:8]);
        ich   = result_t'(w1[15:0]);
        och   = result_t'(w1[31:16]);
        elems = side * side * och;
        case (w0[2:0])
            3'b001: macs = elems * k * k * ich;
            3'b100, 3'b101: macs = elems * k * k;
            // Idle and undefined codes
            default: begin
                elems = '0;
                macs  = '0;
            end
        endcase
        return {macs, elems};
    endfunction

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("Error: time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            o_errors++;
        end
    endtask

    task automatic check_result(apb_addr_t addr, apb_data_t act);
        int          slot;
        int          k;
        int          g;
        logic [63:0] fig;
        slot = int'((addr - RESULT_BASE) >> 3);
        if (last_done <= slot) begin
            $display("Error: time %0t: result slot %0d read before it was written", $time, slot);
            o_errors++;
        end else begin
            // Latest command of this run that landed in the slot
            k = slot + RESULT_DEPTH * ((last_done - 1 - slot) / RESULT_DEPTH);
            g = run_base + k;
            if (words.size() < 3 * (g + 1)) begin
                $display("Error: time %0t: result read for command %0d never written", $time, g);
                o_errors++;
            end else begin
                fig = layer_figures(words[3 * g], words[3 * g + 1]);
                o_result_checks++;
                if (addr[2]) begin
                    compare_value($sformatf("RESULT[%0d].macs", slot), fig[63:32], act);
                end else begin
                    compare_value($sformatf("RESULT[%0d].elems", slot), fig[31:0], act);
                end
            end
        end
    endtask

    task automatic check_status(apb_data_t act);
        int done;
        done = int'(act[14:8]);
        compare_value("STATUS.overflow", 32'(ovf_exp), 32'(act[5]));
        if (idle_exp) begin
            compare_value("STATUS.state", 32'd0, 32'(act[2:0]));
            compare_value("STATUS.irq", 32'd0, 32'(act[4]));
            compare_value("STATUS.done_count", 32'd0, 32'(done));
        end else begin
            // irq only in finish with every command done
            if (act[4]) begin
                compare_value("STATUS.state", 32'd4, 32'(act[2:0]));
                compare_value("STATUS.done_count", 32'(cmd_count), 32'(done));
            end
            if (done < last_done || done > cmd_count) begin
                $display("Error: time %0t: done count %0d went backwards or past %0d",
                         $time, done, cmd_count);
                o_errors++;
            end
        end
        last_done = done;
    endtask

    task automatic track_write(apb_addr_t addr, apb_data_t data);
        case (addr)
            REG_CTRL: begin
                if (data[1]) begin
                    run_base    = run_base + cmd_count;
                    last_done   = 0;
                    idle_exp    = 1'b1;
                    run_started = 1'b0;
                end
                if (data[0]) begin
                    idle_exp    = 1'b0;
                    run_started = 1'b1;
                end
            end
            REG_CMD_COUNT: cmd_count = int'(data[6:0]);
            REG_CMD_DATA: begin
                // Occupancy bound from words pushed and commands seen done
                if (words.size() - 3 * (run_base + last_done) >= FIFO_DEPTH) begin
                    ovf_exp = 1'b1;
                end else begin
                    words.push_back(data);
                end
            end
            default: ;
        endcase
    endtask

    // Sample mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst) begin
            if (i_psel && i_penable && i_pwrite) begin
                track_write(i_paddr, i_pwdata);
            end
            if (i_psel && i_penable && !i_pwrite) begin
                if (i_paddr == REG_STATUS) begin
                    check_status(i_prdata);
                end else if (i_paddr >= RESULT_BASE &&
                             i_paddr < RESULT_BASE + 8 * RESULT_DEPTH) begin
                    check_result(i_paddr, i_prdata);
                end
            end
            // A rising irq needs a started run
            if (i_irq && !irq_q && !run_started) begin
                $display("Error: time %0t: irq rose with no run started", $time);
                o_errors++;
            end
            irq_q <= i_irq;
        end
    end

endmodule

// File: verif/cnn_ctrl_tb.sv
module cnn_ctrl_tb;
    import cnn_cmd_pkg::*;
    import cnn_regs_pkg::*;

    localparam int FIFO_DEPTH     = 16;
    localparam int RESULT_DEPTH   = 16;
    localparam int TOTAL_CMDS     = 5 + 3 + 20 + FIFO_DEPTH / 3;
    localparam int TIMEOUT_CYCLES = TOTAL_CMDS * 40 + 2000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    apb_data_t   status;
    logic        irq;
    int          errors;
    int          result_checks;
    int          local_errors;

    tb_clk_gen clk_gen_i (.o_clk(clk));

    cnn_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH), .RESULT_DEPTH(RESULT_DEPTH)) cnn_ctrl_top_i (
        .clk, .rst, .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_irq(irq)
    );

    cnn_ctrl_checker #(.FIFO_DEPTH(FIFO_DEPTH), .RESULT_DEPTH(RESULT_DEPTH)) checker_i (
        .clk, .rst, .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata), .i_prdata(prdata), .i_irq(irq),
        .o_errors(errors), .o_result_checks(result_checks)
    );

    // Setup phase, access phase, then bus idle
    task automatic apb_write(apb_addr_t addr, apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(apb_addr_t addr, output apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Random layer in three words, OP_IDLE on request
    task automatic push_random_command(logic force_idle);
        logic [2:0] op;
        logic [7:0] side;
        logic [7:0] kernel;
        logic [7:0] i_side;
        logic [15:0] ich;
        logic [15:0] och;
        case ($urandom % 3)
            0: op = 3'b001;
            1: op = 3'b100;
            default: op = 3'b101;
        endcase
        if (force_idle) begin
            op = 3'b000;
        end
        side   = 8'(1 + $urandom % 16);
        kernel = 8'(1 + $urandom % 7);
        i_side = side + 8'($urandom % 8);
        ich    = 16'($urandom % 64);
        och    = 16'($urandom % 64);
        apb_write(REG_CMD_DATA, {side, i_side, kernel, 4'($urandom), 1'b0, op});
        apb_write(REG_CMD_DATA, {och, ich});
        apb_write(REG_CMD_DATA, {16'($urandom), 8'($urandom), 8'h00});
    endtask

    task automatic wait_irq();
        do begin
            apb_read(REG_STATUS, status);
        end while (!status[4]);
    endtask

    task automatic wait_done(int target);
        do begin
            apb_read(REG_STATUS, status);
        end while (int'(status[14:8]) < target);
    endtask

    task automatic read_results(int first, int n);
        apb_data_t data;
        for (int i = first; i < first + n; i++) begin
            apb_read(RESULT_BASE + apb_addr_t'(8 * (i % RESULT_DEPTH)), data);
            apb_read(RESULT_BASE + apb_addr_t'(8 * (i % RESULT_DEPTH) + 4), data);
        end
    endtask

    initial begin
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rst          = 1'b1;
        local_errors = 0;
        void'($urandom(42));
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Status right after reset
        apb_read(REG_STATUS, status);

        // Five commands loaded before start, one of them idle
        for (int i = 0; i < 5; i++) begin
            push_random_command(i == 2);
        end
        apb_write(REG_CMD_COUNT, 5);
        apb_write(REG_CTRL, 32'h1);
        wait_irq();
        read_results(0, 5);

        // Restart clears irq and done count
        apb_write(REG_CTRL, 32'h2);
        apb_read(REG_STATUS, status);

        // Commands trickle in after start
        apb_write(REG_CMD_COUNT, 3);
        apb_write(REG_CTRL, 32'h1);
        for (int i = 0; i < 3; i++) begin
            repeat ($urandom % 20) @(posedge clk);
            push_random_command(1'b0);
        end
        wait_irq();
        read_results(0, 3);

        // Twenty commands in batches, last batch wraps into slots 0 to 3
        apb_write(REG_CTRL, 32'h2);
        apb_write(REG_CMD_COUNT, 20);
        apb_write(REG_CTRL, 32'h1);
        for (int b = 0; b < 5; b++) begin
            for (int i = 0; i < 4; i++) begin
                push_random_command(1'b0);
            end
            if (b < 4) begin
                wait_done(4 * b + 4);
            end else begin
                wait_irq();
            end
            read_results(4 * b, 4);
        end

        // One word more than the FIFO holds while idle
        apb_write(REG_CTRL, 32'h2);
        for (int i = 0; i < FIFO_DEPTH / 3; i++) begin
            push_random_command(1'b0);
        end
        for (int i = 3 * (FIFO_DEPTH / 3); i <= FIFO_DEPTH; i++) begin
            apb_write(REG_CMD_DATA, $urandom);
        end
        apb_read(REG_STATUS, status);
        apb_write(REG_CMD_COUNT, FIFO_DEPTH / 3);
        apb_write(REG_CTRL, 32'h1);
        wait_irq();
        read_results(0, FIFO_DEPTH / 3);

        if (result_checks != 2 * TOTAL_CMDS) begin
            $display("Only %0d of %0d result words were compared", result_checks,
                     2 * TOTAL_CMDS);
            local_errors++;
        end
        $display("Errors: %0d", errors + local_errors);
        if (errors + local_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the command total
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int HALF_PERIOD = 5
) (
    output logic o_clk
);

    // Free-running clock, period of two half periods
    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

endmodule

// File: verilog.f
rtl/cnn_cmd_pkg.sv
rtl/cnn_regs_pkg.sv
rtl/cmd_fifo.sv
rtl/cmd_sequencer.sv
rtl/layer_engine.sv
rtl/apb_ctrl_regs.sv
rtl/cnn_ctrl_top.sv
verif/tb_clk_gen.sv
verif/cnn_ctrl_checker.sv
verif/cnn_ctrl_tb.sv
